//--- rtl/anneal_pkg.sv
// ==============================
// Widths, limits and vector types shared by the annealing front RTL and testbench
// ==============================
package anneal_pkg;

    // Parallel replica lanes behind the dispatcher
    localparam int NUM_LANES = 4;

    // One spin configuration word
    localparam int SPIN_W = 16;

    // Signed energy total carried with every candidate
    localparam int ENERGY_W = 16;

    // Entries kept in each lane's energy history FIFO
    localparam int HIST_DEPTH = 2;

    // Lane number width, never below one bit
    localparam int LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    // Width of the saturating push-none drop counter
    localparam int DROP_W = 16;

    typedef logic [SPIN_W-1:0] spin_t;
    typedef logic signed [ENERGY_W-1:0] energy_t;
    typedef logic [LANE_W-1:0] lane_t;
    typedef logic [DROP_W-1:0] drop_count_t;

    // Largest positive energy, so the first spin on a fresh lane always wins the compare
    localparam energy_t ENERGY_MAX = {1'b0, {(ENERGY_W-1){1'b1}}};

endpackage

//--- rtl/energy_fifo.sv
// ==============================
// Circular FIFO of signed energies; when empty the head repeats the last popped value
// ==============================
module energy_fifo (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                flush_i,
    input  logic                push_i,
    input  logic                pop_i,
    input  anneal_pkg::energy_t data_i,
    output anneal_pkg::energy_t data_o,
    output logic                full_o,
    output logic                empty_o
);
    import anneal_pkg::*;

    // Storage holds payload only, the pointers and count carry the state
    energy_t mem [HIST_DEPTH];

    logic [$clog2(HIST_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(HIST_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(HIST_DEPTH+1)-1:0] count;

    // Copy of the entry most recently popped, shown on the head when nothing is stored
    energy_t last_pop;

    logic do_push;
    logic do_pop;

    assign full_o  = (count == HIST_DEPTH);
    assign empty_o = (count == 0);

    // A pop frees a slot in the same cycle, so a full FIFO still takes a push alongside it
    assign do_pop  = pop_i & ~empty_o;
    assign do_push = push_i & (~full_o | do_pop);

    // Oldest entry, or the remembered value once the FIFO has run dry
    assign data_o = empty_o ? last_pop : mem[rd_ptr];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            last_pop <= ENERGY_MAX;
        end else if (flush_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            last_pop <= ENERGY_MAX;
        end else begin
            if (do_push) begin
                // Wrap explicitly so a depth that is not a power of two also works
                wr_ptr <= (wr_ptr == HIST_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr   <= (rd_ptr == HIST_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
                last_pop <= mem[rd_ptr];
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Memory write port
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr] <= data_i;
        end
    end

endmodule

//--- rtl/spin_pipe.sv
// ==============================
// Single valid/ready register stage for a spin word
// ==============================
module spin_pipe (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              flush_i,
    input  logic              valid_i,
    output logic              ready_o,
    input  anneal_pkg::spin_t data_i,
    output logic              valid_o,
    input  logic              ready_i,
    output anneal_pkg::spin_t data_o
);
    import anneal_pkg::*;

    logic  valid_q;
    spin_t data_q;

    // Free when empty, or when the held word leaves on this edge
    assign ready_o = ~valid_q | ready_i;

    assign valid_o = valid_q;
    assign data_o  = data_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (ready_o) begin
            valid_q <= valid_i;
        end
    end

    // Payload only loads on an accepted transfer and holds through a stall
    always_ff @(posedge clk_i) begin
        if (valid_i && ready_o) begin
            data_q <= data_i;
        end
    end

endmodule

//--- rtl/energy_fifo_maintainer.sv
// ==============================
// One lane with its energy history, push-none decision and spin register stage
// ==============================
module energy_fifo_maintainer (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                flush_i,
    input  logic                en_comparison_i,
    input  logic                energy_valid_i,
    output logic                energy_ready_o,
    input  anneal_pkg::energy_t energy_i,
    input  anneal_pkg::spin_t   spin_i,
    output logic                spin_valid_o,
    input  logic                spin_ready_i,
    output anneal_pkg::spin_t   spin_o,
    output logic                spin_push_none_o
);
    import anneal_pkg::*;

    logic    fifo_full;
    logic    fifo_push;
    logic    fifo_pop;
    energy_t energy_head;
    logic    pipe_ready;
    logic    accept;
    logic    push_none_d;

    // Both the pipe and the history must have room before a candidate is taken
    assign energy_ready_o = pipe_ready & ~fifo_full;
    assign accept         = energy_valid_i & energy_ready_o;

    // Every accepted energy is remembered, and it retires together with its spin
    assign fifo_push = accept;
    assign fifo_pop  = spin_valid_o & spin_ready_i;

    // The head is the previous accepted energy on this lane and a tie counts as no gain
    assign push_none_d = en_comparison_i & (energy_i >= energy_head);

    energy_fifo u_energy_fifo (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .push_i  (fifo_push),
        .pop_i   (fifo_pop),
        .data_i  (energy_i),
        .data_o  (energy_head),
        .full_o  (fifo_full),
        .empty_o ()
    );

    // The pipe only sees valid when the history can also take the energy
    spin_pipe u_spin_pipe (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .valid_i (energy_valid_i & ~fifo_full),
        .ready_o (pipe_ready),
        .data_i  (spin_i),
        .valid_o (spin_valid_o),
        .ready_i (spin_ready_i),
        .data_o  (spin_o)
    );

    // Flag loads on the same edge as the spin, so the two stay aligned downstream
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            spin_push_none_o <= 1'b0;
        end else if (flush_i) begin
            spin_push_none_o <= 1'b0;
        end else if (accept) begin
            spin_push_none_o <= push_none_d;
        end
    end

endmodule

//--- rtl/candidate_dispatcher.sv
// ==============================
// Holds one incoming candidate and offers it to the lane it names
// ==============================
module candidate_dispatcher (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                flush_i,
    input  logic                                in_valid_i,
    output logic                                in_ready_o,
    input  anneal_pkg::lane_t                   in_lane_i,
    input  anneal_pkg::spin_t                   in_spin_i,
    input  anneal_pkg::energy_t                 in_energy_i,
    output logic [anneal_pkg::NUM_LANES-1:0]    lane_valid_o,
    input  logic [anneal_pkg::NUM_LANES-1:0]    lane_ready_i,
    output anneal_pkg::spin_t                   lane_spin_o,
    output anneal_pkg::energy_t                 lane_energy_o
);
    import anneal_pkg::*;

    logic    hold_valid;
    lane_t   hold_lane;
    spin_t   hold_spin;
    energy_t hold_energy;
    logic    drain;

    // Held candidate leaves once its own lane is ready
    assign drain = hold_valid & lane_ready_i[hold_lane];

    // Nothing is taken during a flush, since the register is being emptied
    assign in_ready_o = (~hold_valid | drain) & ~flush_i;

    // Spin and energy go out on shared buses, only the chosen lane sees valid
    assign lane_spin_o   = hold_spin;
    assign lane_energy_o = hold_energy;

    always_comb begin
        for (int k = 0; k < NUM_LANES; k++) begin
            lane_valid_o[k] = hold_valid & (hold_lane == lane_t'(k));
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hold_valid <= 1'b0;
        end else if (flush_i) begin
            hold_valid <= 1'b0;
        end else if (in_ready_o) begin
            hold_valid <= in_valid_i;
        end
    end

    // Candidate payload, refreshed only on an input transfer
    always_ff @(posedge clk_i) begin
        if (in_valid_i && in_ready_o) begin
            hold_lane   <= in_lane_i;
            hold_spin   <= in_spin_i;
            hold_energy <= in_energy_i;
        end
    end

endmodule

//--- rtl/spin_collector.sv
// ==============================
// Round-robin drain of the lanes; forwards good spins, counts and discards push-none ones
// ==============================
module spin_collector (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             flush_i,
    input  logic [anneal_pkg::NUM_LANES-1:0] spin_valid_i,
    output logic [anneal_pkg::NUM_LANES-1:0] spin_ready_o,
    input  anneal_pkg::spin_t                spin_i [anneal_pkg::NUM_LANES],
    input  logic [anneal_pkg::NUM_LANES-1:0] push_none_i,
    output logic                             out_valid_o,
    input  logic                             out_ready_i,
    output anneal_pkg::spin_t                out_spin_o,
    output anneal_pkg::lane_t                out_lane_o,
    output anneal_pkg::drop_count_t          drop_count_o
);
    import anneal_pkg::*;

    lane_t rr_ptr;
    lane_t sel_lane;
    logic  sel_valid;
    logic  drop;
    logic  advance;

    // First valid lane at or after the pointer, wrapping around
    always_comb begin
        lane_t idx;
        sel_valid = 1'b0;
        sel_lane  = rr_ptr;
        for (int i = 0; i < NUM_LANES; i++) begin
            idx = lane_t'(rr_ptr + lane_t'(i));
            if (!sel_valid && spin_valid_i[idx]) begin
                sel_valid = 1'b1;
                sel_lane  = idx;
            end
        end
    end

    // A marked spin is swallowed here and never reaches the output
    assign drop        = sel_valid & push_none_i[sel_lane];
    assign out_valid_o = sel_valid & ~push_none_i[sel_lane];
    assign out_spin_o  = spin_i[sel_lane];
    assign out_lane_o  = sel_lane;

    assign advance = drop | (out_valid_o & out_ready_i);

    always_comb begin
        spin_ready_o = '0;
        spin_ready_o[sel_lane] = advance;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rr_ptr <= '0;
        end else if (flush_i) begin
            rr_ptr <= '0;
        end else if (advance) begin
            rr_ptr <= sel_lane + 1'b1;
        end else if (sel_valid) begin
            // Park on a stalled lane so a newly valid earlier lane cannot steal the output
            rr_ptr <= sel_lane;
        end
    end

    // Saturating count of discarded spins, kept across a flush
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            drop_count_o <= '0;
        end else if (drop && (drop_count_o != '1)) begin
            drop_count_o <= drop_count_o + 1'b1;
        end
    end

endmodule

//--- rtl/anneal_front_top.sv
// ==============================
// Spin-forwarding front: dispatcher, one maintainer per lane, and the collector
// ==============================
module anneal_front_top (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    in_valid_i,
    output logic                    in_ready_o,
    input  anneal_pkg::lane_t       in_lane_i,
    input  anneal_pkg::spin_t       in_spin_i,
    input  anneal_pkg::energy_t     in_energy_i,
    input  logic                    en_comparison_i,
    input  logic                    flush_i,
    output logic                    out_valid_o,
    input  logic                    out_ready_i,
    output anneal_pkg::spin_t       out_spin_o,
    output anneal_pkg::lane_t       out_lane_o,
    output anneal_pkg::drop_count_t drop_count_o
);
    import anneal_pkg::*;

    // Dispatcher to lanes, spin and energy are shared buses
    logic [NUM_LANES-1:0] lane_valid;
    logic [NUM_LANES-1:0] lane_ready;
    spin_t                lane_spin;
    energy_t              lane_energy;

    // Lanes to collector
    logic [NUM_LANES-1:0] spin_valid;
    logic [NUM_LANES-1:0] spin_ready;
    spin_t                spin_data [NUM_LANES];
    logic [NUM_LANES-1:0] push_none;

    candidate_dispatcher u_dispatcher (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .in_valid_i    (in_valid_i),
        .in_ready_o    (in_ready_o),
        .in_lane_i     (in_lane_i),
        .in_spin_i     (in_spin_i),
        .in_energy_i   (in_energy_i),
        .lane_valid_o  (lane_valid),
        .lane_ready_i  (lane_ready),
        .lane_spin_o   (lane_spin),
        .lane_energy_o (lane_energy)
    );

    for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
        energy_fifo_maintainer u_maintainer (
            .clk_i            (clk_i),
            .rst_n_i          (rst_n_i),
            .flush_i          (flush_i),
            .en_comparison_i  (en_comparison_i),
            .energy_valid_i   (lane_valid[k]),
            .energy_ready_o   (lane_ready[k]),
            .energy_i         (lane_energy),
            .spin_i           (lane_spin),
            .spin_valid_o     (spin_valid[k]),
            .spin_ready_i     (spin_ready[k]),
            .spin_o           (spin_data[k]),
            .spin_push_none_o (push_none[k])
        );
    end

    spin_collector u_collector (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .spin_valid_i (spin_valid),
        .spin_ready_o (spin_ready),
        .spin_i       (spin_data),
        .push_none_i  (push_none),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i),
        .out_spin_o   (out_spin_o),
        .out_lane_o   (out_lane_o),
        .drop_count_o (drop_count_o)
    );

endmodule

//--- testbench/anneal_front_props.sv
// ==============================
// Assertions on the front's output handshake and reset state, bound to the top level
// ==============================
module anneal_front_props (
    input logic                    clk_i,
    input logic                    rst_n_i,
    input logic                    flush_i,
    input logic                    out_valid_o,
    input logic                    out_ready_i,
    input anneal_pkg::spin_t       out_spin_o,
    input anneal_pkg::lane_t       out_lane_o,
    input anneal_pkg::drop_count_t drop_count_o
);
    import anneal_pkg::*;

    // Nothing is offered and nothing is counted while reset is held
    reset_quiet: assert property (@(posedge clk_i)
        !rst_n_i |-> (!out_valid_o && (drop_count_o == '0)))
        else $error("output valid or drop count not clear during reset");

    // A stalled output keeps its spin and lane until it is taken, unless a flush empties it
    stall_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (out_valid_o && !out_ready_i && !flush_i)
        |=> (out_valid_o && $stable(out_spin_o) && $stable(out_lane_o)))
        else $error("output changed while stalled");

    // The drop counter only moves up between resets, a flush leaves it alone
    drop_monotonic: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $past(rst_n_i) |-> (drop_count_o >= $past(drop_count_o)))
        else $error("drop counter decreased");

endmodule

bind anneal_front_top anneal_front_props props0 (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .out_spin_o   (out_spin_o),
    .out_lane_o   (out_lane_o),
    .drop_count_o (drop_count_o)
);

//--- testbench/tb_anneal_front.sv
// ==============================
// Self-checking testbench for the annealing front with a lane model and an output monitor
// ==============================
module tb_anneal_front;
    import anneal_pkg::*;

    localparam int          TIMEOUT_CYCLES = 2000;
    localparam int          RANDOM_COUNT   = 300;
    localparam logic [31:0] SEED           = 32'hb224_92c3;

    logic        clk_i;
    logic        rst_n_i;
    logic        in_valid_i;
    logic        in_ready_o;
    lane_t       in_lane_i;
    spin_t       in_spin_i;
    energy_t     in_energy_i;
    logic        en_comparison_i;
    logic        flush_i;
    logic        out_valid_o;
    logic        out_ready_i;
    spin_t       out_spin_o;
    lane_t       out_lane_o;
    drop_count_t drop_count_o;

    // The model keeps the last accepted energy and the spins still owed on each lane
    energy_t last_energy [NUM_LANES];
    spin_t   expect_q [NUM_LANES][$];
    spin_t   monitor_spin;
    int      expected_drops;

    logic        random_ready;
    logic        aborted;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          test_errors_at_start;
    string       test_name;
    logic [31:0] stim_state;
    logic [31:0] ready_state;

    anneal_front_top dut0 (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .in_valid_i      (in_valid_i),
        .in_ready_o      (in_ready_o),
        .in_lane_i       (in_lane_i),
        .in_spin_i       (in_spin_i),
        .in_energy_i     (in_energy_i),
        .en_comparison_i (en_comparison_i),
        .flush_i         (flush_i),
        .out_valid_o     (out_valid_o),
        .out_ready_i     (out_ready_i),
        .out_spin_o      (out_spin_o),
        .out_lane_o      (out_lane_o),
        .drop_count_o    (drop_count_o)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #50 clk_i = ~clk_i;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // A spin is dropped when comparison is on and it does not strictly lower the lane energy
    function automatic logic predict_drop(input energy_t prev, input energy_t energy,
                                          input logic en_cmp);
        return en_cmp && (energy >= prev);
    endfunction

    function automatic logic lanes_empty();
        for (int k = 0; k < NUM_LANES; k++) begin
            if (expect_q[k].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // Fresh lanes and flushed lanes both compare against the largest energy
    task automatic reset_model();
        for (int k = 0; k < NUM_LANES; k++) begin
            last_energy[k] = ENERGY_MAX;
        end
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("CHECK FAILED: test %s, %s: expected %0h, actual %0h",
                 test_name, what, expected, actual);
        errors++;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors_at_start = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == test_errors_at_start) begin
            $display("PASS  %s", test_name);
        end else begin
            tests_failed++;
            $display("FAIL  %s (%0d errors)", test_name, errors - test_errors_at_start);
        end
    endtask

    // Offers one candidate from a falling edge and books it in the model once it is taken
    task automatic send(input lane_t lane, input spin_t spin, input energy_t energy);
        int   waited;
        logic taken;
        waited = 0;
        taken  = 1'b0;
        if (!aborted) begin
            in_valid_i  = 1'b1;
            in_lane_i   = lane;
            in_spin_i   = spin;
            in_energy_i = energy;
            while (!taken && waited < TIMEOUT_CYCLES) begin
                @(posedge clk_i);
                taken = in_ready_o;
                waited++;
            end
            if (taken) begin
                if (predict_drop(last_energy[lane], energy, en_comparison_i)) begin
                    expected_drops++;
                end else begin
                    expect_q[lane].push_back(spin);
                end
                last_energy[lane] = energy;
            end else begin
                $display("TIMEOUT: test %s, input on lane %0d was never accepted",
                         test_name, lane);
                errors++;
                aborted = 1'b1;
            end
            @(negedge clk_i);
            in_valid_i = 1'b0;
        end
    endtask

    // Waits until every owed spin came out and the counter reached the predicted drops
    task automatic wait_drain();
        int   waited;
        logic done;
        waited = 0;
        done   = 1'b0;
        while (!aborted && !done && waited < TIMEOUT_CYCLES) begin
            @(negedge clk_i);
            done = lanes_empty() && !out_valid_o &&
                   (drop_count_o >= drop_count_t'(expected_drops));
            waited++;
        end
        if (!aborted && !done) begin
            $display("TIMEOUT: test %s, lanes did not drain (drop count %0d, model %0d)",
                     test_name, drop_count_o, expected_drops);
            errors++;
            aborted = 1'b1;
        end
    endtask

    // Every output transfer must match the oldest owed spin of its lane
    always @(posedge clk_i) begin
        if (rst_n_i && out_valid_o && out_ready_i) begin
            if (expect_q[out_lane_o].size() == 0) begin
                $display("ERROR: test %s, unexpected spin %0h on lane %0d",
                         test_name, out_spin_o, out_lane_o);
                errors++;
            end else begin
                monitor_spin = expect_q[out_lane_o].pop_front();
                if (out_spin_o !== monitor_spin) begin
                    report_mismatch($sformatf("spin on lane %0d", out_lane_o),
                                    monitor_spin, out_spin_o);
                end
            end
        end
    end

    // Back-pressure mode is read on the rising edge, so the falling edge drive never races it
    initial begin
        logic use_random;
        out_ready_i = 1'b1;
        forever begin
            @(posedge clk_i);
            use_random = random_ready;
            @(negedge clk_i);
            if (use_random) begin
                ready_state = xorshift(ready_state);
                out_ready_i = |ready_state[1:0];
            end else begin
                out_ready_i = 1'b1;
            end
        end
    end

    task automatic verify_reset_state();
        start_test("reset_state");
        @(negedge clk_i);
        if (in_ready_o !== 1'b1) begin
            report_mismatch("in_ready_o", 1, in_ready_o);
        end
        if (out_valid_o !== 1'b0) begin
            report_mismatch("out_valid_o", 0, out_valid_o);
        end
        if (drop_count_o !== '0) begin
            report_mismatch("drop_count_o", 0, drop_count_o);
        end
        end_test();
    endtask

    // Worst possible energy on every lane is still forwarded with comparison off
    task automatic forward_without_compare();
        drop_count_t base;
        start_test("compare_disabled");
        base = drop_count_o;
        en_comparison_i = 1'b0;
        for (int k = 0; k < NUM_LANES; k++) begin
            stim_state = xorshift(stim_state);
            send(lane_t'(k), spin_t'(stim_state[15:0]), ENERGY_MAX);
        end
        wait_drain();
        if (drop_count_o !== base) begin
            report_mismatch("drop_count_o", base, drop_count_o);
        end
        end_test();
    endtask

    task automatic drop_on_compare();
        energy_t     seq [7] = '{16'sd100, 16'sd100, 16'sd150, 16'sd40, 16'sd40,
                                 -16'sd20, 16'sd0};
        drop_count_t base;
        int          drops_before;
        start_test("compare_drop");
        base         = drop_count_o;
        drops_before = expected_drops;
        en_comparison_i = 1'b1;
        for (int n = 0; n < 7; n++) begin
            send(lane_t'(2), spin_t'(16'hc000 + n), seq[n]);
        end
        wait_drain();
        if (drop_count_t'(drop_count_o - base) !==
            drop_count_t'(expected_drops - drops_before)) begin
            report_mismatch("drop count rise", expected_drops - drops_before,
                            drop_count_o - base);
        end
        end_test();
    endtask

    task automatic stress_random_traffic();
        lane_t lane;
        spin_t spin;
        start_test("random_traffic");
        en_comparison_i = 1'b1;
        random_ready    = 1'b1;
        for (int n = 0; n < RANDOM_COUNT; n++) begin
            stim_state = xorshift(stim_state);
            lane = lane_t'(stim_state[LANE_W-1:0]);
            spin = spin_t'(stim_state[31:16]);
            stim_state = xorshift(stim_state);
            send(lane, spin, energy_t'(stim_state[15:0]));
            // Leave an occasional idle cycle on the input
            if (stim_state[20:19] == 2'b00) begin
                @(negedge clk_i);
            end
        end
        wait_drain();
        random_ready = 1'b0;
        if (drop_count_o !== drop_count_t'(expected_drops)) begin
            report_mismatch("final drop_count_o", expected_drops, drop_count_o);
        end
        end_test();
    endtask

    // Low energies first, then a flush, then high energies that only pass on fresh history
    task automatic refill_after_flush();
        drop_count_t base;
        start_test("flush_idle");
        en_comparison_i = 1'b1;
        for (int k = 0; k < NUM_LANES; k++) begin
            send(lane_t'(k), spin_t'(16'h1000 + k), -16'sd1000);
        end
        wait_drain();
        base = drop_count_o;
        flush_i = 1'b1;
        @(negedge clk_i);
        flush_i = 1'b0;
        reset_model();
        if (drop_count_o !== base) begin
            report_mismatch("drop_count_o after flush", base, drop_count_o);
        end
        for (int k = 0; k < NUM_LANES; k++) begin
            send(lane_t'(k), spin_t'(16'h2000 + k), energy_t'(ENERGY_MAX - 1 - k));
        end
        wait_drain();
        if (drop_count_o !== base) begin
            report_mismatch("drop_count_o after refill", base, drop_count_o);
        end
        end_test();
    endtask

    initial begin
        rst_n_i         = 1'b1;
        in_valid_i      = 1'b0;
        in_lane_i       = '0;
        in_spin_i       = '0;
        in_energy_i     = '0;
        en_comparison_i = 1'b0;
        flush_i         = 1'b0;
        random_ready    = 1'b0;
        aborted         = 1'b0;
        errors          = 0;
        tests_run       = 0;
        tests_failed    = 0;
        expected_drops  = 0;
        test_name       = "setup";
        stim_state      = SEED;
        ready_state     = xorshift(SEED);
        reset_model();

        // A clean falling reset edge, then two cycles in reset
        #10 rst_n_i = 1'b0;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;

        verify_reset_state();
        if (!aborted) begin
            forward_without_compare();
        end
        if (!aborted) begin
            drop_on_compare();
        end
        if (!aborted) begin
            stress_random_traffic();
        end
        if (!aborted) begin
            refill_after_flush();
        end

        $display("Summary: %0d tests run, %0d failed, %0d errors",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- build.f
rtl/anneal_pkg.sv
rtl/energy_fifo.sv
rtl/spin_pipe.sv
rtl/energy_fifo_maintainer.sv
rtl/candidate_dispatcher.sv
rtl/spin_collector.sv
rtl/anneal_front_top.sv
testbench/anneal_front_props.sv
testbench/tb_anneal_front.sv

//--- run.sh
#!/bin/sh
# Verilate and run the testbench, then decide the result from the pass line in its output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_anneal_front -f build.f || exit 1
sim_out="$(./obj_dir/Vtb_anneal_front)"
echo "$sim_out"
echo "$sim_out" | grep -q "All tests passed" && echo "RESULT: PASS" || { echo "RESULT: FAIL"; exit 1; }
